// File: nebula_ii.f
+incdir+verilog
verilog/nebula_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_decoder.sv
verilog/wb_sram.sv
verilog/gpio_control.sv
verilog/team_copy_engine.sv
verilog/nebula_ii.sv
tb/nebula_ii_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the nebula_ii testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module nebula_ii_tb -f nebula_ii.f --Mdir obj_dir

out=$(./obj_dir/Vnebula_ii_tb)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: tb/nebula_ii_tb.sv
// Testbench for the nebula_ii user area driven through the host Wishbone port
// Keeps a word model of the SRAM and checks GPIO, copy engine and decode holes
`default_nettype none

`include "nebula_defines.svh"

module nebula_ii_tb;

    logic        wb_clk_i;
    logic        rst_n_i;
    logic        wbs_cyc_i;
    logic        wbs_stb_i;
    logic        wbs_we_i;
    logic [3:0]  wbs_sel_i;
    logic [31:0] wbs_adr_i;
    logic [31:0] wbs_dat_i;
    logic [37:0] io_in_i;
    wire         wbs_ack_o;
    wire  [31:0] wbs_dat_o;
    wire  [37:0] io_out_o;
    wire  [37:0] io_oeb_o;
    wire  [2:0]  irq_o;

    // Expected SRAM contents with one entry per word
    logic [31:0] model_mem [`NEBULA_SRAM_WORDS];
    int          err_cnt;
    int          test_err;
    int          pass_cnt;
    int          fail_cnt;

    nebula_ii dut_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wbs_cyc_i(wbs_cyc_i),
        .wbs_stb_i(wbs_stb_i),
        .wbs_we_i (wbs_we_i),
        .wbs_sel_i(wbs_sel_i),
        .wbs_adr_i(wbs_adr_i),
        .wbs_dat_i(wbs_dat_i),
        .wbs_ack_o(wbs_ack_o),
        .wbs_dat_o(wbs_dat_o),
        .io_in_i  (io_in_i),
        .io_out_o (io_out_o),
        .io_oeb_o (io_oeb_o),
        .irq_o    (irq_o)
    );

    // 100 unit clock period
    always #50 wb_clk_i = ~wb_clk_i;

    function automatic logic [31:0] sram_adr(input int idx);
        return `NEBULA_SRAM_BASE | {20'd0, idx[9:0], 2'b00};
    endfunction

    function automatic logic [31:0] reg_adr(input logic [31:0] base, input logic [7:0] off);
        return base | {24'd0, off};
    endfunction

    // Merges byte lanes into the model and returns the word a read should give
    function automatic logic [31:0] model_write(input int idx, input logic [31:0] dat,
                                                input logic [3:0] sel);
        logic [31:0] w;
        w = model_mem[idx[9:0]];
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = dat[8*b +: 8];
            end
        end
        model_mem[idx[9:0]] = w;
        return w;
    endfunction

    task automatic check(input string msg, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %0t: %s, expected %h got %h", $time, msg, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic start_test();
        test_err = err_cnt;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err) begin
            $display("Test %s: ok", name);
            pass_cnt++;
        end else begin
            $display("Test %s: failed with %0d errors", name, err_cnt - test_err);
            fail_cnt++;
        end
    endtask

    // One classic cycle with ack sampled mid-cycle where it has settled
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int n;
        @(posedge wb_clk_i);
        #1;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = sel;
        wbs_adr_i = adr;
        wbs_dat_i = dat;
        n = 0;
        @(negedge wb_clk_i);
        while (!wbs_ack_o && n < 100) begin
            @(negedge wb_clk_i);
            n++;
        end
        if (!wbs_ack_o) begin
            $display("Timeout: host access to address %h was not acked in 100 cycles", adr);
            err_cnt++;
        end
        rdat = wbs_dat_o;
        // Release after the ack edge
        @(posedge wb_clk_i);
        #1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic host_write(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, dat, sel, unused_rd);
    endtask

    task automatic host_read(input logic [31:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'd0, 4'hF, dat);
    endtask

    task automatic fill_src(input int src, input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = $urandom();
            host_write(sram_adr(src + i), r, 4'hF);
            void'(model_write(src + i, r, 4'hF));
        end
    endtask

    task automatic start_copy(input int src, input int dst, input int len);
        host_write(reg_adr(`NEBULA_COPY_BASE, `COPY_SRC), sram_adr(src), 4'hF);
        host_write(reg_adr(`NEBULA_COPY_BASE, `COPY_DST), sram_adr(dst), 4'hF);
        host_write(reg_adr(`NEBULA_COPY_BASE, `COPY_LEN), len, 4'hF);
        host_write(reg_adr(`NEBULA_COPY_BASE, `COPY_CTRL), 32'h1, 4'hF);
    endtask

    // Poll STATUS until the done bit shows up
    task automatic wait_copy_done(input int limit);
        logic [31:0] st;
        int n;
        n = 0;
        host_read(reg_adr(`NEBULA_COPY_BASE, `COPY_STATUS), st);
        while (!st[1] && n < limit) begin
            host_read(reg_adr(`NEBULA_COPY_BASE, `COPY_STATUS), st);
            n++;
        end
        if (!st[1]) begin
            $display("Timeout: copy engine did not report done after %0d status polls", limit);
            err_cnt++;
        end
    endtask

    // Destination must hold the source words
    task automatic verify_copy(input int src, input int dst, input int len);
        logic [31:0] rd;
        for (int i = 0; i < len; i++) begin
            host_read(sram_adr(dst + i), rd);
            check("copied word", model_mem[(src + i) % 1024], rd);
            // Model follows the copy
            void'(model_write(dst + i, model_mem[(src + i) % 1024], 4'hF));
        end
    endtask

    task automatic clear_done();
        logic [31:0] st;
        host_write(reg_adr(`NEBULA_COPY_BASE, `COPY_STATUS), 32'h2, 4'hF);
        @(negedge wb_clk_i);
        check("irq after clear", 32'd0, {29'd0, irq_o});
        host_read(reg_adr(`NEBULA_COPY_BASE, `COPY_STATUS), st);
        check("status after clear", 32'd0, st);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] prev;
        logic [31:0] r;
        logic [31:0] exp_w;
        logic [63:0] r64;
        logic [37:0] out_v;
        logic [37:0] oeb_v;
        logic [37:0] pads;
        int          idx;
        int          n;
        void'($urandom(32'h29b5_2787));
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_err  = 0;
        wb_clk_i  = 1'b0;
        rst_n_i   = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'h0;
        wbs_adr_i = 32'd0;
        wbs_dat_i = 32'd0;
        io_in_i   = 38'd0;
        repeat (10) @(posedge wb_clk_i);
        #1;
        rst_n_i = 1'b1;

        // Pads idle as inputs with no interrupt pending
        start_test();
        @(negedge wb_clk_i);
        check("oeb low after reset", 32'hFFFF_FFFF, io_oeb_o[31:0]);
        check("oeb high after reset", 32'h0000_003F, {26'd0, io_oeb_o[37:32]});
        check("out low after reset", 32'd0, io_out_o[31:0]);
        check("out high after reset", 32'd0, {26'd0, io_out_o[37:32]});
        check("irq after reset", 32'd0, {29'd0, irq_o});
        end_test("reset state");

        // Full init of words 0..63 then random byte lanes
        start_test();
        for (int i = 0; i < 64; i++) begin
            r = $urandom();
            host_write(sram_adr(i), r, 4'hF);
            void'(model_write(i, r, 4'hF));
        end
        for (int i = 0; i < 48; i++) begin
            idx = $urandom_range(63, 0);
            r   = $urandom();
            exp_w = model_write(idx, r, r[7:4] ^ r[27:24]);
            host_write(sram_adr(idx), r, r[7:4] ^ r[27:24]);
            host_read(sram_adr(idx), rd);
            check("sram byte write readback", exp_w, rd);
        end
        end_test("sram byte selects");

        start_test();
        r64   = {$urandom(), $urandom()};
        out_v = r64[37:0];
        r64   = {$urandom(), $urandom()};
        oeb_v = r64[37:0];
        host_write(reg_adr(`NEBULA_GPIO_BASE, `GPIO_OUT_LO), out_v[31:0], 4'hF);
        host_write(reg_adr(`NEBULA_GPIO_BASE, `GPIO_OUT_HI), {26'd0, out_v[37:32]}, 4'hF);
        host_write(reg_adr(`NEBULA_GPIO_BASE, `GPIO_OEB_LO), oeb_v[31:0], 4'hF);
        host_write(reg_adr(`NEBULA_GPIO_BASE, `GPIO_OEB_HI), {26'd0, oeb_v[37:32]}, 4'hF);
        @(negedge wb_clk_i);
        check("io_out low", out_v[31:0], io_out_o[31:0]);
        check("io_out high", {26'd0, out_v[37:32]}, {26'd0, io_out_o[37:32]});
        check("io_oeb low", oeb_v[31:0], io_oeb_o[31:0]);
        check("io_oeb high", {26'd0, oeb_v[37:32]}, {26'd0, io_oeb_o[37:32]});
        r64 = {$urandom(), $urandom()};
        pads = r64[37:0];
        @(posedge wb_clk_i);
        #1;
        io_in_i = pads;
        // Synchronizer delay, settled once two reads agree
        n = 0;
        host_read(reg_adr(`NEBULA_GPIO_BASE, `GPIO_IN_LO), prev);
        host_read(reg_adr(`NEBULA_GPIO_BASE, `GPIO_IN_LO), rd);
        while (rd !== prev && n < 20) begin
            prev = rd;
            host_read(reg_adr(`NEBULA_GPIO_BASE, `GPIO_IN_LO), rd);
            n++;
        end
        if (rd !== prev) begin
            $display("Timeout: GPIO input readback did not settle after 20 polls");
            err_cnt++;
        end
        check("pad input low", pads[31:0], rd);
        host_read(reg_adr(`NEBULA_GPIO_BASE, `GPIO_IN_HI), rd);
        check("pad input high", {26'd0, pads[37:32]}, rd);
        end_test("gpio");

        // 16 words from 64 to 256
        start_test();
        fill_src(64, 16);
        start_copy(64, 256, 16);
        wait_copy_done(200);
        @(negedge wb_clk_i);
        check("irq after copy", 32'd1, {29'd0, irq_o});
        verify_copy(64, 256, 16);
        clear_done();
        end_test("block copy");

        // Long copy while the host works in words 0..63
        start_test();
        fill_src(384, 128);
        start_copy(384, 640, 128);
        for (int i = 0; i < 40; i++) begin
            idx = $urandom_range(63, 0);
            r   = $urandom();
            if (r[31]) begin
                void'(model_write(idx, r, r[3:0]));
                host_write(sram_adr(idx), r, r[3:0]);
            end else begin
                host_read(sram_adr(idx), rd);
                check("host read during copy", model_mem[idx % 1024], rd);
            end
        end
        wait_copy_done(500);
        verify_copy(384, 640, 128);
        for (int i = 0; i < 64; i++) begin
            host_read(sram_adr(i), rd);
            check("host word after copy", model_mem[i], rd);
        end
        clear_done();
        end_test("contention");

        // Hole in the map answers with zero
        start_test();
        host_write(32'h3003_0000, 32'hA5A5_5A5A, 4'hF);
        host_read(32'h3003_0000, rd);
        check("unmapped read data", 32'd0, rd);
        end_test("unmapped address");

        $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/nebula_ii.sv
// User-area top, host Wishbone port and copy engine share one bus
// Slaves are SRAM, GPIO control and the copy engine registers
`default_nettype none

module nebula_ii (
    input  wire         wb_clk_i,
    input  wire         rst_n_i,
    input  wire         wbs_cyc_i,
    input  wire         wbs_stb_i,
    input  wire         wbs_we_i,
    input  wire  [3:0]  wbs_sel_i,
    input  wire  [31:0] wbs_adr_i,
    input  wire  [31:0] wbs_dat_i,
    output wire         wbs_ack_o,
    output wire  [31:0] wbs_dat_o,
    input  wire  [37:0] io_in_i,
    output wire  [37:0] io_out_o,
    output wire  [37:0] io_oeb_o,
    output wire  [2:0]  irq_o
);

    nebula_pkg::wb_req_t [1:0] mgr_req;
    nebula_pkg::wb_rsp_t [1:0] mgr_rsp;
    nebula_pkg::wb_req_t       bus_req;
    nebula_pkg::wb_rsp_t       bus_rsp;
    nebula_pkg::wb_req_t       sram_req;
    nebula_pkg::wb_rsp_t       sram_rsp;
    nebula_pkg::wb_req_t       gpio_req;
    nebula_pkg::wb_rsp_t       gpio_rsp;
    nebula_pkg::wb_req_t       copy_req;
    nebula_pkg::wb_rsp_t       copy_rsp;
    wire                       copy_irq;

    // Host pins as manager 0
    assign mgr_req[0] = '{cyc: wbs_cyc_i, stb: wbs_stb_i, we: wbs_we_i,
                          sel: wbs_sel_i, adr: wbs_adr_i, dat: wbs_dat_i};
    assign wbs_ack_o  = mgr_rsp[0].ack;
    assign wbs_dat_o  = mgr_rsp[0].dat;

    // Only the copy done interrupt is used
    assign irq_o = {2'b00, copy_irq};

    wb_arbiter arb_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .mgr_req_i(mgr_req),
        .mgr_rsp_o(mgr_rsp),
        .bus_req_o(bus_req),
        .bus_rsp_i(bus_rsp)
    );

    wb_decoder dec_i (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .sram_req_o(sram_req),
        .sram_rsp_i(sram_rsp),
        .gpio_req_o(gpio_req),
        .gpio_rsp_i(gpio_rsp),
        .copy_req_o(copy_req),
        .copy_rsp_i(copy_rsp)
    );

    wb_sram sram_i (
        .wb_clk_i(wb_clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (sram_req),
        .rsp_o   (sram_rsp)
    );

    gpio_control gpio_i (
        .wb_clk_i(wb_clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (gpio_req),
        .rsp_o   (gpio_rsp),
        .io_in_i (io_in_i),
        .io_out_o(io_out_o),
        .io_oeb_o(io_oeb_o)
    );

    // Team design, slave for setup and manager 1 for copies
    team_copy_engine copy_i (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .slv_req_i(copy_req),
        .slv_rsp_o(copy_rsp),
        .mst_req_o(mgr_req[1]),
        .mst_rsp_i(mgr_rsp[1]),
        .irq_o    (copy_irq)
    );

endmodule

`default_nettype wire

// File: verilog/team_copy_engine.sv
// Team block that copies LEN words from SRC to DST over the shared bus
// Programmed through its slave port, raises irq_o when a copy is done
`default_nettype none

`include "nebula_defines.svh"

module team_copy_engine (
    input  wire                      wb_clk_i,
    input  wire                      rst_n_i,
    input  wire nebula_pkg::wb_req_t slv_req_i,
    output nebula_pkg::wb_rsp_t      slv_rsp_o,
    output nebula_pkg::wb_req_t      mst_req_o,
    input  wire nebula_pkg::wb_rsp_t mst_rsp_i,
    output logic                     irq_o
);

    logic [31:0] src_q;
    logic [31:0] dst_q;
    logic [31:0] len_q;
    logic [31:0] idx_q;
    logic [31:0] data_q;
    logic [31:0] rd_word;
    logic [31:0] rd_q;
    logic        ack_q;
    logic        busy_q;
    logic        done_q;
    logic        phase_q;
    logic        cyc_q;
    logic        slv_wr;
    logic        start;
    logic        done_clr;
    logic        mst_ack;
    logic        last_word;

    assign slv_wr   = slv_req_i.cyc && slv_req_i.stb && !ack_q && slv_req_i.we;
    // CTRL bit 0 starts, ignored while a copy runs
    assign start    = slv_wr && (slv_req_i.adr[7:0] == `COPY_CTRL) && slv_req_i.dat[0] && !busy_q;
    assign done_clr = slv_wr && (slv_req_i.adr[7:0] == `COPY_STATUS) && slv_req_i.dat[1];
    assign mst_ack  = busy_q && cyc_q && mst_rsp_i.ack;
    assign last_word = (idx_q + 32'd1 == len_q);

    always_comb begin
        case (slv_req_i.adr[7:0])
            `COPY_SRC:    rd_word = src_q;
            `COPY_DST:    rd_word = dst_q;
            `COPY_LEN:    rd_word = len_q;
            `COPY_STATUS: rd_word = {30'd0, done_q, busy_q};
            default:      rd_word = '0;
        endcase
    end

    // Slave side, config held steady during a copy
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= slv_req_i.cyc && slv_req_i.stb && !ack_q;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        rd_q <= rd_word;
        if (slv_wr && !busy_q) begin
            case (slv_req_i.adr[7:0])
                `COPY_SRC: src_q <= slv_req_i.dat;
                `COPY_DST: dst_q <= slv_req_i.dat;
                `COPY_LEN: len_q <= slv_req_i.dat;
                default: ;
            endcase
        end
        // Word in flight between read and write
        if (mst_ack && !phase_q) begin
            data_q <= mst_rsp_i.dat;
        end
    end

    // Read then write per word, cyc drops for a cycle after each ack
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            phase_q <= 1'b0;
            cyc_q   <= 1'b0;
            idx_q   <= '0;
        end else if (start) begin
            idx_q   <= '0;
            phase_q <= 1'b0;
            // Zero length finishes at once
            busy_q  <= (len_q != 32'd0);
            cyc_q   <= (len_q != 32'd0);
            done_q  <= (len_q == 32'd0);
        end else if (busy_q) begin
            if (mst_ack) begin
                cyc_q <= 1'b0;
                if (phase_q) begin
                    phase_q <= 1'b0;
                    idx_q   <= idx_q + 32'd1;
                    if (last_word) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end
                end else begin
                    phase_q <= 1'b1;
                end
            end else if (!cyc_q) begin
                cyc_q <= 1'b1;
            end
        end else if (done_clr) begin
            done_q <= 1'b0;
        end
    end

    always_comb begin
        mst_req_o.cyc = cyc_q;
        mst_req_o.stb = cyc_q;
        mst_req_o.we  = phase_q;
        mst_req_o.sel = 4'hF;
        mst_req_o.adr = (phase_q ? dst_q : src_q) + {idx_q[29:0], 2'b00};
        mst_req_o.dat = data_q;
    end

    assign slv_rsp_o.ack = ack_q;
    assign slv_rsp_o.dat = rd_q;
    assign irq_o         = done_q;

endmodule

`default_nettype wire

// File: verilog/gpio_control.sv
// Pad control for the 38 user IOs, out and oeb registers on Wishbone
// Pad inputs read back after a two-flop synchronizer
`default_nettype none

`include "nebula_defines.svh"

module gpio_control (
    input  wire                      wb_clk_i,
    input  wire                      rst_n_i,
    input  wire nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t      rsp_o,
    input  wire [37:0]               io_in_i,
    output logic [37:0]              io_out_o,
    output logic [37:0]              io_oeb_o
);

    logic [37:0] out_q;
    logic [37:0] oeb_q;
    logic [37:0] sync1_q;
    logic [37:0] sync2_q;
    logic [31:0] cur_w;
    logic [31:0] wr_w;
    logic [31:0] rd_q;
    logic        ack_q;
    logic        acc;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign acc = req_i.cyc && req_i.stb && !ack_q;

    // Addressed register, HI words carry pads 37:32 in bits 5:0
    always_comb begin
        case (req_i.adr[7:0])
            `GPIO_OUT_LO: cur_w = out_q[31:0];
            `GPIO_OUT_HI: cur_w = {26'd0, out_q[37:32]};
            `GPIO_OEB_LO: cur_w = oeb_q[31:0];
            `GPIO_OEB_HI: cur_w = {26'd0, oeb_q[37:32]};
            `GPIO_IN_LO:  cur_w = sync2_q[31:0];
            `GPIO_IN_HI:  cur_w = {26'd0, sync2_q[37:32]};
            default:      cur_w = '0;
        endcase
    end

    assign wr_w = merge_bytes(cur_w, req_i.dat, req_i.sel);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            // Pads start as inputs
            oeb_q   <= '1;
            sync1_q <= '0;
            sync2_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            sync1_q <= io_in_i;
            sync2_q <= sync1_q;
            ack_q   <= acc;
            if (acc && req_i.we) begin
                // IN registers are read only
                case (req_i.adr[7:0])
                    `GPIO_OUT_LO: out_q[31:0]  <= wr_w;
                    `GPIO_OUT_HI: out_q[37:32] <= wr_w[5:0];
                    `GPIO_OEB_LO: oeb_q[31:0]  <= wr_w;
                    `GPIO_OEB_HI: oeb_q[37:32] <= wr_w[5:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (acc) begin
            rd_q <= cur_w;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rd_q;
    assign io_out_o  = out_q;
    assign io_oeb_o  = oeb_q;

endmodule

`default_nettype wire

// File: verilog/wb_sram.sv
// 1024 x 32 SRAM with byte writes behind a Wishbone classic slave port
// Acks one cycle after a request, read data comes with the ack
`default_nettype none

`include "nebula_defines.svh"

module wb_sram (
    input  wire                      wb_clk_i,
    input  wire                      rst_n_i,
    input  wire nebula_pkg::wb_req_t req_i,
    output nebula_pkg::wb_rsp_t      rsp_o
);

    logic [31:0] mem [`NEBULA_SRAM_WORDS];
    logic [31:0] rd_q;
    logic [9:0]  idx;
    logic        ack_q;
    logic        acc;

    // Word index from byte address
    assign idx = req_i.adr[11:2];

    // New access, masked in the ack cycle
    assign acc = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc;
        end
    end

    // Array and read word
    always_ff @(posedge wb_clk_i) begin
        if (acc) begin
            if (req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    // Untouched lanes keep their old byte
                    if (req_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
            rd_q <= mem[idx];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = rd_q;

endmodule

`default_nettype wire

// File: verilog/wb_decoder.sv
// Address decoder between the arbiter and the three slaves
// Unmapped addresses are acked here with zero read data
`default_nettype none

`include "nebula_defines.svh"

module wb_decoder (
    input  wire                      wb_clk_i,
    input  wire                      rst_n_i,
    input  wire nebula_pkg::wb_req_t bus_req_i,
    output nebula_pkg::wb_rsp_t      bus_rsp_o,
    output nebula_pkg::wb_req_t      sram_req_o,
    input  wire nebula_pkg::wb_rsp_t sram_rsp_i,
    output nebula_pkg::wb_req_t      gpio_req_o,
    input  wire nebula_pkg::wb_rsp_t gpio_rsp_i,
    output nebula_pkg::wb_req_t      copy_req_o,
    input  wire nebula_pkg::wb_rsp_t copy_rsp_i
);

    logic [31:0] region;
    logic        hit_sram;
    logic        hit_gpio;
    logic        hit_copy;
    logic        miss;
    logic        miss_ack_q;

    assign region   = bus_req_i.adr & `NEBULA_REGION_MASK;
    assign hit_sram = (region == `NEBULA_SRAM_BASE);
    assign hit_gpio = (region == `NEBULA_GPIO_BASE);
    assign hit_copy = (region == `NEBULA_COPY_BASE);
    assign miss     = !(hit_sram || hit_gpio || hit_copy);

    always_comb begin
        sram_req_o = bus_req_i;
        gpio_req_o = bus_req_i;
        copy_req_o = bus_req_i;
        // Strobes reach only the matching slave
        sram_req_o.cyc = bus_req_i.cyc && hit_sram;
        sram_req_o.stb = bus_req_i.stb && hit_sram;
        gpio_req_o.cyc = bus_req_i.cyc && hit_gpio;
        gpio_req_o.stb = bus_req_i.stb && hit_gpio;
        copy_req_o.cyc = bus_req_i.cyc && hit_copy;
        copy_req_o.stb = bus_req_i.stb && hit_copy;
    end

    // One-cycle ack for a hole in the map, writes go nowhere
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            miss_ack_q <= 1'b0;
        end else begin
            miss_ack_q <= bus_req_i.cyc && bus_req_i.stb && miss && !miss_ack_q;
        end
    end

    // Address is held until ack, so it still selects the answer
    always_comb begin
        if (hit_sram) begin
            bus_rsp_o = sram_rsp_i;
        end else if (hit_gpio) begin
            bus_rsp_o = gpio_rsp_i;
        end else if (hit_copy) begin
            bus_rsp_o = copy_rsp_i;
        end else begin
            bus_rsp_o.ack = miss_ack_q;
            bus_rsp_o.dat = '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_arbiter.sv
// Round-robin arbiter for two Wishbone managers on one shared bus
// Manager 0 is the host port, manager 1 the copy engine
`default_nettype none

module wb_arbiter (
    input  wire                            wb_clk_i,
    input  wire                            rst_n_i,
    input  wire nebula_pkg::wb_req_t [1:0] mgr_req_i,
    output nebula_pkg::wb_rsp_t [1:0]      mgr_rsp_o,
    output nebula_pkg::wb_req_t            bus_req_o,
    input  wire nebula_pkg::wb_rsp_t       bus_rsp_i
);

    logic busy_q;
    logic owner_q;
    logic last_q;
    logic last_srv;
    logic release_bus;
    logic any_req;
    logic pick;

    // Free when idle or once the owner has dropped cyc
    assign release_bus = !busy_q || !mgr_req_i[owner_q].cyc;
    assign any_req     = mgr_req_i[0].cyc || mgr_req_i[1].cyc;

    // Owner finishing now counts as the one served last
    assign last_srv = busy_q ? owner_q : last_q;

    always_comb begin
        // Both asking, the other one goes first
        if (mgr_req_i[0].cyc && mgr_req_i[1].cyc) begin
            pick = ~last_srv;
        end else begin
            pick = mgr_req_i[1].cyc;
        end
    end

    // Grant lands on the next edge and holds while owner keeps cyc
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            // Host wins the first tie
            last_q  <= 1'b1;
        end else if (release_bus) begin
            busy_q <= any_req;
            last_q <= last_srv;
            if (any_req) begin
                owner_q <= pick;
            end
        end
    end

    // Only the owner reaches the bus
    assign bus_req_o = busy_q ? mgr_req_i[owner_q] : '0;

    always_comb begin
        for (int m = 0; m < 2; m++) begin
            mgr_rsp_o[m].dat = bus_rsp_i.dat;
            // Ack steered to the owner, others see it low
            mgr_rsp_o[m].ack = busy_q && (owner_q == m[0]) && bus_rsp_i.ack;
        end
    end

endmodule

`default_nettype wire

// File: verilog/nebula_pkg.sv
// Wishbone request and response types shared by all managers and slaves
// Referenced by scoped name, one struct per direction
`default_nettype none

package nebula_pkg;

    // Manager toward slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Slave toward manager
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/nebula_defines.svh
// Address map, register offsets and SRAM depth of the nebula_ii user area
// Included by every block that decodes a bus address
`ifndef NEBULA_DEFINES_SVH
`define NEBULA_DEFINES_SVH

// Regions are 64 KB each, matched on adr[31:16]
`define NEBULA_REGION_MASK 32'hFFFF_0000
`define NEBULA_SRAM_BASE   32'h3000_0000
`define NEBULA_GPIO_BASE   32'h3001_0000
`define NEBULA_COPY_BASE   32'h3002_0000
`define NEBULA_SRAM_WORDS  1024

// GPIO block, byte offsets within its region
`define GPIO_OUT_LO 8'h00
`define GPIO_OUT_HI 8'h04
`define GPIO_OEB_LO 8'h08
`define GPIO_OEB_HI 8'h0C
`define GPIO_IN_LO  8'h10
`define GPIO_IN_HI  8'h14

// Copy engine registers
`define COPY_SRC    8'h00
`define COPY_DST    8'h04
`define COPY_LEN    8'h08
`define COPY_CTRL   8'h0C
`define COPY_STATUS 8'h10

`endif
